// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

   // ------------------------------------------------------------------------
   // Widths and basic types
   // ------------------------------------------------------------------------
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_idx_t;   // Register index, x0..x31
   typedef logic [2:0]      funct3_t;

   // ------------------------------------------------------------------------
   // Major opcodes, inst[6:0]
   // ------------------------------------------------------------------------
   typedef enum logic [6:0] {
      op_r      = 7'b0110011,   // add sub and or
      op_imm    = 7'b0010011,   // addi andi ori xori slli
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_branch = 7'b1100011,   // beq bne
      op_lui    = 7'b0110111,
      op_jal    = 7'b1101111
   } opcode_t;

   // ALU operations
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_sll
   } alu_op_t;

   // addi x0, x0, 0
   localparam word_t nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire logic            clk,
   input  wire logic            reset,
   input  wire logic            we,
   input  wire rv_pkg::reg_idx_t rs1,
   input  wire rv_pkg::reg_idx_t rs2,
   input  wire rv_pkg::reg_idx_t rd,
   input  wire rv_pkg::word_t   rd_data,
   output rv_pkg::word_t        rs1_data,
   output rv_pkg::word_t        rs2_data
);

   rv_pkg::word_t regs [1:31];   // x0 has no storage

   always_ff @(posedge clk)
   begin
      if (we && rd != '0)
         regs[rd] <= rd_data;
   end

   // Write-through so decode sees the value retiring this cycle
   assign rs1_data = (rs1 == '0)            ? '0      :
                     (we && rd == rs1)      ? rd_data : regs[rs1];
   assign rs2_data = (rs2 == '0)            ? '0      :
                     (we && rd == rs2)      ? rd_data : regs[rs2];

   // Decode drops x0 writes before they reach write-back
   a_x0_zero: assert property (@(posedge clk) disable iff (reset)
      we |-> (rd != '0));

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
   parameter rv_pkg::word_t reset_pc = '0
) (
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          stall,
   input  wire logic          redirect,
   input  wire rv_pkg::word_t redirect_pc,
   input  wire rv_pkg::word_t inst,
   output rv_pkg::word_t      pc,
   output rv_pkg::word_t      ifid_pc,
   output rv_pkg::word_t      ifid_inst
);

   // Program counter, redirect wins over stall
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pc        <= reset_pc;
         ifid_inst <= rv_pkg::nop_inst;
      end
      else if (redirect)
      begin
         pc        <= redirect_pc;
         ifid_inst <= rv_pkg::nop_inst;   // Squash the slot being fetched
      end
      else if (!stall)
      begin
         pc        <= pc + 32'd4;
         ifid_inst <= inst;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall || redirect)
         ifid_pc <= pc;
   end

   // Branch and jal targets from execute keep the fetch address aligned
   a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             redirect,
   input  wire rv_pkg::word_t    ifid_pc,
   input  wire rv_pkg::word_t    ifid_inst,
   input  wire logic             wb_we,
   input  wire rv_pkg::reg_idx_t wb_rd,
   input  wire rv_pkg::word_t    wb_data,
   output logic                  stall,
   output logic                  idex_reg_write,
   output logic                  idex_mem_to_reg,
   output logic                  idex_mem_write,
   output logic                  idex_branch,
   output logic                  idex_jal,
   output logic                  idex_alu_src,
   output logic                  idex_lui,
   output rv_pkg::alu_op_t       idex_alu_op,
   output rv_pkg::funct3_t       idex_funct3,
   output rv_pkg::word_t         idex_pc,
   output rv_pkg::word_t         idex_rs1_data,
   output rv_pkg::word_t         idex_rs2_data,
   output rv_pkg::word_t         idex_imm,
   output rv_pkg::reg_idx_t      idex_rs1,
   output rv_pkg::reg_idx_t      idex_rs2,
   output rv_pkg::reg_idx_t      idex_rd
);

   logic [6:0]       opcode;
   logic [6:0]       funct7;
   rv_pkg::funct3_t  funct3;
   rv_pkg::reg_idx_t rs1, rs2, rd;
   logic             reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui;
   rv_pkg::alu_op_t  alu_op;
   logic             alu_ok;
   rv_pkg::word_t    imm, rs1_data, rs2_data;
   logic             bubble;
   logic [31:0]      inst;

   assign inst   = ifid_inst;
   assign opcode = inst[6:0];
   assign rd     = inst[11:7];
   assign funct3 = inst[14:12];
   assign rs1    = inst[19:15];
   assign rs2    = inst[24:20];
   assign funct7 = inst[31:25];

   // ------------------------------------------------------------------------
   // Main decoder and immediate select
   // ------------------------------------------------------------------------
   always_comb
   begin
      {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b0;
      imm = '0;
      case (opcode)
         rv_pkg::op_r:      {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b1000000;
         rv_pkg::op_imm:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b1100000;
            imm = {{20{inst[31]}}, inst[31:20]};
         end
         rv_pkg::op_load:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b1110000;
            imm = {{20{inst[31]}}, inst[31:20]};
         end
         rv_pkg::op_store:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b0101000;
            imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         end
         rv_pkg::op_branch:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b0000100;
            imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         end
         rv_pkg::op_lui:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b1100001;
            imm = {inst[31:12], 12'b0};
         end
         rv_pkg::op_jal:
         begin
            {reg_write, alu_src, mem_to_reg, mem_write, branch, jal, lui} = 7'b1000010;
            imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         default: ;   // Unknown opcode runs as a bubble
      endcase
   end

   // ALU decoder
   always_comb
   begin
      alu_op = rv_pkg::alu_add;   // Address calc and lui
      alu_ok = 1'b1;
      case (opcode)
         rv_pkg::op_r:
            case ({funct7, funct3})
               10'b0000000_000: alu_op = rv_pkg::alu_add;
               10'b0100000_000: alu_op = rv_pkg::alu_sub;
               10'b0000000_111: alu_op = rv_pkg::alu_and;
               10'b0000000_110: alu_op = rv_pkg::alu_or;
               default:         alu_ok = 1'b0;
            endcase
         rv_pkg::op_imm:
            case (funct3)
               3'b000:  alu_op = rv_pkg::alu_add;
               3'b111:  alu_op = rv_pkg::alu_and;
               3'b110:  alu_op = rv_pkg::alu_or;
               3'b100:  alu_op = rv_pkg::alu_xor;
               3'b001:
               begin
                  alu_op = rv_pkg::alu_sll;
                  alu_ok = (funct7 == 7'b0);
               end
               default: alu_ok = 1'b0;
            endcase
         default: ;
      endcase
   end

   reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .we       (wb_we),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (wb_rd),
      .rd_data  (wb_data),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // Load-use against the load now in execute
   assign stall  = idex_mem_to_reg && (idex_rd == rs1 || idex_rd == rs2);
   assign bubble = stall || redirect;

   // ------------------------------------------------------------------------
   // Decode/execute register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         {idex_reg_write, idex_mem_to_reg, idex_mem_write} <= 3'b0;
         {idex_branch, idex_jal, idex_alu_src, idex_lui}   <= 4'b0;
      end
      else
      begin
         idex_reg_write  <= reg_write && (rd != '0) && !bubble;   // x0 writes dropped here
         idex_mem_to_reg <= mem_to_reg && !bubble;
         idex_mem_write  <= mem_write && !bubble;
         idex_branch     <= branch && !bubble;
         idex_jal        <= jal && !bubble;
         idex_alu_src    <= alu_src && !bubble;
         idex_lui        <= lui && !bubble;
      end
   end

   always_ff @(posedge clk)
   begin
      idex_alu_op   <= alu_op;
      idex_funct3   <= funct3;
      idex_pc       <= ifid_pc;
      idex_rs1_data <= rs1_data;
      idex_rs2_data <= rs2_data;
      idex_imm      <= imm;
      idex_rs1      <= rs1;
      idex_rs2      <= rs2;
      idex_rd       <= rd;
   end

   // Arithmetic encodings reaching decode must be ones the ALU knows
   a_alu_known: assert property (@(posedge clk) disable iff (reset)
      (opcode inside {rv_pkg::op_r, rv_pkg::op_imm}) && !redirect |-> alu_ok);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             idex_reg_write,
   input  wire logic             idex_mem_to_reg,
   input  wire logic             idex_mem_write,
   input  wire logic             idex_branch,
   input  wire logic             idex_jal,
   input  wire logic             idex_alu_src,
   input  wire logic             idex_lui,
   input  wire rv_pkg::alu_op_t  idex_alu_op,
   input  wire rv_pkg::funct3_t  idex_funct3,
   input  wire rv_pkg::word_t    idex_pc,
   input  wire rv_pkg::word_t    idex_rs1_data,
   input  wire rv_pkg::word_t    idex_rs2_data,
   input  wire rv_pkg::word_t    idex_imm,
   input  wire rv_pkg::reg_idx_t idex_rs1,
   input  wire rv_pkg::reg_idx_t idex_rs2,
   input  wire rv_pkg::reg_idx_t idex_rd,
   input  wire logic             wb_we,
   input  wire rv_pkg::reg_idx_t wb_rd,
   input  wire rv_pkg::word_t    wb_data,
   output logic                  redirect,
   output rv_pkg::word_t         redirect_pc,
   output logic                  exmem_reg_write,
   output logic                  exmem_mem_to_reg,
   output logic                  exmem_mem_write,
   output rv_pkg::reg_idx_t      exmem_rd,
   output rv_pkg::word_t         exmem_result,
   output rv_pkg::word_t         exmem_store_data
);

   rv_pkg::word_t fwd_a, fwd_b, op_a, op_b, alu_out, result;
   logic          taken;

   // Newest producer first, a load in exmem is covered by the stall
   function automatic rv_pkg::word_t forward(input rv_pkg::reg_idx_t rs,
                                             input rv_pkg::word_t    rs_data);
      if (exmem_reg_write && !exmem_mem_to_reg && exmem_rd == rs && rs != '0)
         forward = exmem_result;
      else if (wb_we && wb_rd == rs && rs != '0)
         forward = wb_data;
      else
         forward = rs_data;
   endfunction

   always_comb
   begin
      fwd_a = forward(idex_rs1, idex_rs1_data);
      fwd_b = forward(idex_rs2, idex_rs2_data);
   end

   assign op_a = idex_lui ? '0 : fwd_a;       // lui adds to zero
   assign op_b = idex_alu_src ? idex_imm : fwd_b;

   // ------------------------------------------------------------------------
   // ALU
   // ------------------------------------------------------------------------
   always_comb
   begin
      case (idex_alu_op)
         rv_pkg::alu_sub: alu_out = op_a - op_b;
         rv_pkg::alu_and: alu_out = op_a & op_b;
         rv_pkg::alu_or:  alu_out = op_a | op_b;
         rv_pkg::alu_xor: alu_out = op_a ^ op_b;
         rv_pkg::alu_sll: alu_out = op_a << op_b[4:0];
         default:         alu_out = op_a + op_b;
      endcase
   end

   // Branch resolution, beq and bne only
   always_comb
   begin
      case (idex_funct3)
         3'b000:  taken = idex_branch && (fwd_a == fwd_b);
         3'b001:  taken = idex_branch && (fwd_a != fwd_b);
         default: taken = 1'b0;
      endcase
   end

   assign redirect    = taken || idex_jal;
   assign redirect_pc = idex_pc + idex_imm;
   assign result      = idex_jal ? idex_pc + 32'd4 : alu_out;   // Link value

   // ------------------------------------------------------------------------
   // Execute/memory register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         exmem_reg_write  <= 1'b0;
         exmem_mem_to_reg <= 1'b0;
         exmem_mem_write  <= 1'b0;
      end
      else
      begin
         exmem_reg_write  <= idex_reg_write;
         exmem_mem_to_reg <= idex_mem_to_reg;
         exmem_mem_write  <= idex_mem_write;
      end
   end

   always_ff @(posedge clk)
   begin
      exmem_rd         <= idex_rd;
      exmem_result     <= result;
      exmem_store_data <= fwd_b;   // Store data sees forwarding too
   end

   // Decode drops x0 writes, so a squash never overlaps one in exmem
   a_redirect_no_x0: assert property (@(posedge clk) disable iff (reset)
      redirect |-> !(exmem_reg_write && exmem_rd == '0));

endmodule

`default_nettype wire

// ==== rtl/mem_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             exmem_reg_write,
   input  wire logic             exmem_mem_to_reg,
   input  wire rv_pkg::reg_idx_t exmem_rd,
   input  wire rv_pkg::word_t    exmem_result,
   input  wire rv_pkg::word_t    mem_rdata,
   output logic                  wb_we,
   output rv_pkg::reg_idx_t      wb_rd,
   output rv_pkg::word_t         wb_data
);

   logic          wb_mem_to_reg;
   rv_pkg::word_t wb_result;
   rv_pkg::word_t wb_rdata;   // Loaded word, captured at the edge

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wb_we         <= 1'b0;
         wb_mem_to_reg <= 1'b0;
      end
      else
      begin
         wb_we         <= exmem_reg_write;
         wb_mem_to_reg <= exmem_mem_to_reg;
      end
   end

   always_ff @(posedge clk)
   begin
      wb_rd     <= exmem_rd;
      wb_result <= exmem_result;
      wb_rdata  <= mem_rdata;
   end

   // Write-back select
   assign wb_data = wb_mem_to_reg ? wb_rdata : wb_result;

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
   parameter rv_pkg::word_t reset_pc = '0
) (
   input  wire logic          clk,
   input  wire logic          reset,
   output rv_pkg::word_t      pc,
   input  wire rv_pkg::word_t inst,
   output logic               mem_write,
   output rv_pkg::word_t      mem_addr,
   output rv_pkg::word_t      mem_wdata,
   input  wire rv_pkg::word_t mem_rdata
);

   logic             stall, redirect;
   rv_pkg::word_t    redirect_pc, ifid_pc, ifid_inst;
   logic             idex_reg_write, idex_mem_to_reg, idex_mem_write;
   logic             idex_branch, idex_jal, idex_alu_src, idex_lui;
   rv_pkg::alu_op_t  idex_alu_op;
   rv_pkg::funct3_t  idex_funct3;
   rv_pkg::word_t    idex_pc, idex_rs1_data, idex_rs2_data, idex_imm;
   rv_pkg::reg_idx_t idex_rs1, idex_rs2, idex_rd;
   logic             exmem_reg_write, exmem_mem_to_reg, exmem_mem_write;
   rv_pkg::reg_idx_t exmem_rd, wb_rd;
   rv_pkg::word_t    exmem_result, exmem_store_data, wb_data;
   logic             wb_we;

   fetch_stage #(.reset_pc(reset_pc)) u_fetch (
      .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
      .redirect_pc(redirect_pc), .inst(inst),
      .pc(pc), .ifid_pc(ifid_pc), .ifid_inst(ifid_inst)
   );

   decode_stage u_decode (
      .clk(clk), .reset(reset), .redirect(redirect),
      .ifid_pc(ifid_pc), .ifid_inst(ifid_inst),
      .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data), .stall(stall),
      .idex_reg_write(idex_reg_write), .idex_mem_to_reg(idex_mem_to_reg),
      .idex_mem_write(idex_mem_write), .idex_branch(idex_branch),
      .idex_jal(idex_jal), .idex_alu_src(idex_alu_src), .idex_lui(idex_lui),
      .idex_alu_op(idex_alu_op), .idex_funct3(idex_funct3), .idex_pc(idex_pc),
      .idex_rs1_data(idex_rs1_data), .idex_rs2_data(idex_rs2_data),
      .idex_imm(idex_imm), .idex_rs1(idex_rs1), .idex_rs2(idex_rs2),
      .idex_rd(idex_rd)
   );

   execute_stage u_execute (
      .clk(clk), .reset(reset),
      .idex_reg_write(idex_reg_write), .idex_mem_to_reg(idex_mem_to_reg),
      .idex_mem_write(idex_mem_write), .idex_branch(idex_branch),
      .idex_jal(idex_jal), .idex_alu_src(idex_alu_src), .idex_lui(idex_lui),
      .idex_alu_op(idex_alu_op), .idex_funct3(idex_funct3), .idex_pc(idex_pc),
      .idex_rs1_data(idex_rs1_data), .idex_rs2_data(idex_rs2_data),
      .idex_imm(idex_imm), .idex_rs1(idex_rs1), .idex_rs2(idex_rs2),
      .idex_rd(idex_rd), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .exmem_reg_write(exmem_reg_write), .exmem_mem_to_reg(exmem_mem_to_reg),
      .exmem_mem_write(exmem_mem_write), .exmem_rd(exmem_rd),
      .exmem_result(exmem_result), .exmem_store_data(exmem_store_data)
   );

   mem_wb_stage u_mem_wb (
      .clk(clk), .reset(reset),
      .exmem_reg_write(exmem_reg_write), .exmem_mem_to_reg(exmem_mem_to_reg),
      .exmem_rd(exmem_rd), .exmem_result(exmem_result), .mem_rdata(mem_rdata),
      .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
   );

   // Data memory port, driven from the memory stage
   assign mem_write = exmem_mem_write;
   assign mem_addr  = exmem_result;
   assign mem_wdata = exmem_store_data;

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
   parameter int half_period = 10   // 20 ns period
) (
   output logic clk
);

   initial
      clk = 1'b0;

   always
      #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

   localparam rv_pkg::word_t reset_pc   = 32'h0000_0100;
   localparam int            imem_depth = 64;
   localparam int            dmem_depth = 64;

   logic          clk;
   logic          reset;
   logic          mem_write;
   rv_pkg::word_t pc, inst, mem_addr, mem_wdata, mem_rdata, imem_off;

   rv_pkg::word_t imem [0:imem_depth-1];
   rv_pkg::word_t dmem [0:dmem_depth-1];
   rv_pkg::word_t prog[$];                    // Program being built
   rv_pkg::word_t log_addr[$], log_data[$];   // Stores seen on the bus, in order
   rv_pkg::word_t exp_addr[$], exp_data[$];
   rv_pkg::word_t end_pc;                     // Closing self-loop jal
   integer        seed = 32'hdd4a;
   int            errors = 0;
   int            checks = 0;
   int            cycles = 0;
   int            len_total = 0;

   tb_clock clock0 (.clk(clk));

   rv_core #(.reset_pc(reset_pc)) dut0 (
      .clk(clk), .reset(reset), .pc(pc), .inst(inst), .mem_write(mem_write),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

   // ------------------------------------------------------------------------
   // Memory models
   // ------------------------------------------------------------------------
   assign imem_off  = pc - reset_pc;
   assign inst      = (imem_off[31:2] < imem_depth) ? imem[imem_off[31:2]]
                                                    : rv_pkg::nop_inst;
   assign mem_rdata = dmem[mem_addr[7:2]];

   always @(negedge clk)
   begin
      if (mem_write === 1'b1)
      begin
         log_addr.push_back(mem_addr);
         log_data.push_back(mem_wdata);
         dmem[mem_addr[7:2]] = mem_wdata;
      end
   end

   // Watchdog, limit grows as programs are loaded
   always @(negedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > len_total * 4 + 100)
      begin
         $display("timeout: program did not reach its final loop after %0d cycles", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic check_word(input string name, input rv_pkg::word_t actual,
                             input rv_pkg::word_t expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic check_count(input string name, input int actual, input int expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("mismatch %s: got %0h, expected %0h", name, actual, expected);
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   // ------------------------------------------------------------------------
   // Instruction encoders, RV32I formats
   // ------------------------------------------------------------------------
   function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::funct3_t f3,
                                            input rv_pkg::reg_idx_t rd, rs1, rs2);
      r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic rv_pkg::word_t i_type(input logic [6:0] opc, input rv_pkg::funct3_t f3,
                                            input rv_pkg::reg_idx_t rd, rs1,
                                            input logic [11:0] imm);
      i_type = {imm, rs1, f3, rd, opc};
   endfunction

   function automatic rv_pkg::word_t s_type(input rv_pkg::reg_idx_t rs1, rs2,
                                            input logic [11:0] imm);
      s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
   endfunction

   function automatic rv_pkg::word_t b_type(input rv_pkg::funct3_t f3,
                                            input rv_pkg::reg_idx_t rs1, rs2,
                                            input logic [12:0] imm);
      b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic rv_pkg::word_t j_type(input rv_pkg::reg_idx_t rd, input logic [20:0] imm);
      j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic rv_pkg::word_t u_type(input rv_pkg::reg_idx_t rd, input logic [19:0] imm);
      u_type = {imm, rd, 7'b0110111};   // lui
   endfunction

   function automatic rv_pkg::word_t sign_extend(input logic [11:0] v);
      sign_extend = {{20{v[11]}}, v};
   endfunction

   // Background data, differs at every word address
   function automatic rv_pkg::word_t fill_word(input int idx);
      rv_pkg::word_t addr;
      addr      = idx * 4;
      fill_word = {addr[15:0] ^ 16'hc35a, ~addr[15:0]};
   endfunction

   // ------------------------------------------------------------------------
   // Program building and running
   // ------------------------------------------------------------------------
   task automatic load_const(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t value);
      rv_pkg::word_t hi;
      hi = value + 32'h800;   // Compensates the sign of the addi part
      prog.push_back(u_type(rd, hi[31:12]));
      prog.push_back(i_type(7'b0010011, 3'b000, rd, rd, value[11:0]));
   endtask

   task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic op_then_store(input rv_pkg::word_t op, input rv_pkg::reg_idx_t src,
                                input logic [11:0] addr, input rv_pkg::word_t value);
      prog.push_back(op);
      prog.push_back(s_type(5'd0, src, addr));
      expect_store({20'h0, addr}, value);
   endtask

   // Leaves reset high so a test can still preset data memory
   task automatic load_and_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (4) @(negedge clk);
      check_word("pc", pc, reset_pc);
      check_bit("mem_write", mem_write, 1'b0);
      for (int i = 0; i < imem_depth; i++)
         imem[i] = (i < prog.size()) ? prog[i] : rv_pkg::nop_inst;
      for (int i = 0; i < dmem_depth; i++)
         dmem[i] = fill_word(i);
      log_addr.delete();
      log_data.delete();
      len_total += prog.size();
      end_pc = reset_pc + 4 * (prog.size() - 1);
   endtask

   task automatic compare_stores(input string name);
      int n;
      n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
      check_count({name, " store count"}, log_addr.size(), exp_addr.size());
      for (int i = 0; i < n; i++)
      begin
         check_word($sformatf("%s store %0d addr", name, i), log_addr[i], exp_addr[i]);
         check_word($sformatf("%s store %0d data", name, i), log_data[i], exp_data[i]);
      end
   endtask

   // Second arrival at the self loop means its jal resolved and older stores retired
   task automatic run_to_end(input string name);
      int   entries;
      logic at_end;
      entries = 0;
      at_end  = 1'b0;
      reset   = 1'b0;
      while (entries < 2)
      begin
         @(negedge clk);
         if (pc == end_pc && !at_end)
            entries++;
         at_end = (pc == end_pc);
      end
      compare_stores(name);
      prog.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic after_reset();
      prog.push_back(j_type(5'd0, 21'd0));
      load_and_reset();
      run_to_end("after_reset");
   endtask

   task automatic alu_chain();
      rv_pkg::word_t a, b, v;
      logic [11:0]   i1, i2, i3, i4;
      logic [4:0]    sh;
      a  = $random(seed);
      b  = $random(seed);
      i1 = $random(seed);
      i2 = $random(seed);
      i3 = $random(seed);
      i4 = $random(seed);
      sh = $random(seed);
      load_const(5'd1, a);
      load_const(5'd2, b);
      v = a + b;
      op_then_store(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 12'h040, v);
      v = v - a;
      op_then_store(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 5'd4, 12'h044, v);
      v = v & a;
      op_then_store(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd1), 5'd5, 12'h048, v);
      v = v | (a + b);
      op_then_store(r_type(7'h00, 3'b110, 5'd6, 5'd5, 5'd3), 5'd6, 12'h04c, v);
      v = v + sign_extend(i1);
      op_then_store(i_type(7'b0010011, 3'b000, 5'd7, 5'd6, i1), 5'd7, 12'h050, v);
      v = v & sign_extend(i2);
      op_then_store(i_type(7'b0010011, 3'b111, 5'd8, 5'd7, i2), 5'd8, 12'h054, v);
      v = v | sign_extend(i3);
      op_then_store(i_type(7'b0010011, 3'b110, 5'd9, 5'd8, i3), 5'd9, 12'h058, v);
      v = v ^ sign_extend(i4);
      op_then_store(i_type(7'b0010011, 3'b100, 5'd10, 5'd9, i4), 5'd10, 12'h05c, v);
      v = v << sh;
      op_then_store(i_type(7'b0010011, 3'b001, 5'd11, 5'd10, {7'b0, sh}), 5'd11, 12'h060, v);
      prog.push_back(j_type(5'd0, 21'd0));
      load_and_reset();
      run_to_end("alu_chain");
   endtask

   task automatic load_use();
      rv_pkg::word_t b, ld, sum;
      b   = $random(seed);
      ld  = $random(seed);
      sum = ld + b;
      load_const(5'd2, b);
      prog.push_back(i_type(7'b0000011, 3'b010, 5'd1, 5'd0, 12'h080));   // lw x1
      // Uses x1 at once, stall on rs1
      op_then_store(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 12'h084, sum);
      prog.push_back(i_type(7'b0000011, 3'b010, 5'd4, 5'd0, 12'h084));   // Reload the sum
      // Stall on rs2 this time
      op_then_store(r_type(7'h20, 3'b000, 5'd5, 5'd2, 5'd4), 5'd5, 12'h088, b - sum);
      prog.push_back(j_type(5'd0, 21'd0));
      load_and_reset();
      dmem[32'h080 >> 2] = ld;
      run_to_end("load_use");
   endtask

   task automatic branch_squash();
      rv_pkg::word_t a;
      a = $random(seed);
      load_const(5'd3, ~a);
      load_const(5'd1, a);
      load_const(5'd2, a);
      prog.push_back(b_type(3'b000, 5'd1, 5'd2, 13'd12));   // beq taken
      prog.push_back(s_type(5'd0, 5'd1, 12'h090));
      prog.push_back(s_type(5'd0, 5'd1, 12'h094));
      prog.push_back(s_type(5'd0, 5'd1, 12'h0a0));          // Target
      expect_store(32'h0a0, a);
      prog.push_back(b_type(3'b000, 5'd1, 5'd3, 13'd12));   // beq not taken
      prog.push_back(s_type(5'd0, 5'd3, 12'h0a4));
      expect_store(32'h0a4, ~a);
      prog.push_back(b_type(3'b001, 5'd1, 5'd3, 13'd12));   // bne taken
      prog.push_back(s_type(5'd0, 5'd1, 12'h098));
      prog.push_back(s_type(5'd0, 5'd1, 12'h09c));
      prog.push_back(s_type(5'd0, 5'd2, 12'h0a8));
      expect_store(32'h0a8, a);
      prog.push_back(b_type(3'b001, 5'd1, 5'd2, 13'd12));   // bne not taken
      prog.push_back(s_type(5'd0, 5'd3, 12'h0ac));
      expect_store(32'h0ac, ~a);
      prog.push_back(j_type(5'd0, 21'd0));
      load_and_reset();
      run_to_end("branch_squash");
   endtask

   task automatic jal_and_lui();
      logic [19:0] u;
      u = $random(seed);
      prog.push_back(j_type(5'd1, 21'd12));   // Over two slots
      prog.push_back(s_type(5'd0, 5'd0, 12'h0b0));
      prog.push_back(s_type(5'd0, 5'd0, 12'h0b4));
      prog.push_back(s_type(5'd0, 5'd1, 12'h0b8));
      expect_store(32'h0b8, reset_pc + 32'd4);
      op_then_store(u_type(5'd5, u), 5'd5, 12'h0bc, {u, 12'h000});
      // Target is the second squashed slot, fetched again
      prog.push_back(j_type(5'd6, 21'd8));
      prog.push_back(s_type(5'd0, 5'd0, 12'h0c0));
      prog.push_back(s_type(5'd0, 5'd6, 12'h0c4));
      expect_store(32'h0c4, reset_pc + 32'd28);
      prog.push_back(j_type(5'd0, 21'd0));
      load_and_reset();
      run_to_end("jal_and_lui");
   endtask

   initial
   begin
      reset = 1'b1;
      for (int i = 0; i < imem_depth; i++)
         imem[i] = rv_pkg::nop_inst;
      for (int i = 0; i < dmem_depth; i++)
         dmem[i] = fill_word(i);
      after_reset();
      alu_chain();
      load_use();
      branch_squash();
      jal_and_lui();
      $display("errors %0d in %0d checks", errors, checks);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core.sv
tb/tb_clock.sv
tb/tb_rv_core.sv
